// ==== Bender.yml ====
package:
  name: xgmii_rx

sources:
  - source/xgmii_rx_pkg.sv
  - source/xgmii_lane_decode.sv
  - source/eth_crc32_engine.sv
  - source/xgmii_frame_fsm.sv
  - source/xgmii_rx_top.sv
  - target: test
    files:
      - testbench/xgmii_rx_assert.sv
      - testbench/tb_xgmii_rx.sv

// ==== build.f ====
source/xgmii_rx_pkg.sv
source/xgmii_lane_decode.sv
source/eth_crc32_engine.sv
source/xgmii_frame_fsm.sv
source/xgmii_rx_top.sv
testbench/xgmii_rx_assert.sv
testbench/tb_xgmii_rx.sv

// ==== source/eth_crc32_engine.sv ====
/*
 * Ethernet CRC-32 engine
 * running reflected CRC over the stage0 word with 1 to 4 byte
 * partial results; each partial is compared with the good-frame
 * residue and the four comparisons are kept for the frame FSM
 */
`timescale 1ns/1ps

module eth_crc32_engine (
    input  logic                    clk,
    input  logic                    reset_crc,
    input  logic                    crc_clear,
    input  logic                    crc_update,
    input  logic [31:0]             data,
    output xgmii_rx_pkg::crc_match_t match
);

    import xgmii_rx_pkg::*;

    logic [31:0]       crc_state;
    // crc_next[i] has consumed lanes 0..i
    logic [3:0][31:0]  crc_next;
    logic [3:0]        hit;

    // byte chain, lane 0 enters first
    always_comb begin
        crc_next[0] = crc32_step(crc_state, data[7:0]);
        for (int i = 1; i < 4; i++) begin
            crc_next[i] = crc32_step(crc_next[i-1], data[8*i +: 8]);
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            hit[i] = (crc_next[i] == crc_residue);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc || crc_clear) begin
            crc_state <= crc_init;
            match     <= '0;
        end else if (crc_update) begin
            // state always advances by the full word
            crc_state <= crc_next[3];
            match.hit <= hit;
        end
    end

endmodule

// ==== source/xgmii_frame_fsm.sv ====
/*
 * XGMII frame FSM
 * drops start and preamble words, emits payload and FCS as
 * AXI-Stream style beats from stage2, sets tkeep on the last beat
 * and judges the frame with the saved CRC comparisons
 */
`timescale 1ns/1ps

module xgmii_frame_fsm (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  xgmii_rx_pkg::xgmii_word_t  stage1,
    input  xgmii_rx_pkg::xgmii_word_t  stage2,
    input  xgmii_rx_pkg::lane_flags_t  flags,
    input  logic [3:0]                term_saved,
    input  xgmii_rx_pkg::crc_match_t   match,
    output xgmii_rx_pkg::axis_beat_t   m_axis,
    output xgmii_rx_pkg::rx_status_t   status,
    output logic                      crc_clear,
    output logic                      crc_update
);

    import xgmii_rx_pkg::*;

    fsm_state_t state;
    fsm_state_t state_next;

    // lane 0 start seen in stage1 [0] and stage2 [1]
    logic [1:0] start_pipe;

    // terminate word info, held until st_last
    logic [3:0] last_keep;
    logic       last_ctrl_bad;
    logic       last_fcs_ok;
    logic       last_fcs_ok_next;

    axis_beat_t beat_next;
    rx_status_t status_next;

    always_comb begin
        state_next       = state;
        beat_next        = '0;
        status_next      = '0;
        crc_clear        = 1'b0;
        crc_update       = 1'b0;
        last_fcs_ok_next = last_fcs_ok;

        case (state)
            st_idle: begin
                crc_clear = 1'b1;
                if (start_pipe[1]) begin
                    // stage1 is the preamble word, stage0 the first data word
                    if (|flags.err_masked || |stage1.ctrl) begin
                        beat_next.tkeep  = 4'b0001;
                        beat_next.tvalid = 1'b1;
                        beat_next.tlast  = 1'b1;
                        beat_next.tuser  = 1'b1;
                        status_next.bad_frame = 1'b1;
                    end else begin
                        crc_clear  = 1'b0;
                        crc_update = 1'b1;
                        state_next = st_preamble;
                    end
                end
            end
            st_preamble: begin
                // preamble/sfd word leaves stage2 without a beat
                crc_update = !flags.term[0];
                state_next = st_payload;
            end
            st_payload: begin
                beat_next.tdata  = stage2.data;
                beat_next.tkeep  = 4'b1111;
                beat_next.tvalid = 1'b1;
                if (|stage2.ctrl) begin
                    // control or error character inside the packet
                    beat_next.tlast = 1'b1;
                    beat_next.tuser = 1'b1;
                    status_next.bad_frame = 1'b1;
                    crc_clear  = 1'b1;
                    state_next = st_idle;
                end else if (term_saved[0]) begin
                    // terminate on lane 0 of the next word, fcs ends here
                    beat_next.tlast = 1'b1;
                    if (!match.hit[3]) begin
                        beat_next.tuser = 1'b1;
                        status_next.bad_frame = 1'b1;
                        status_next.bad_fcs   = 1'b1;
                    end
                    crc_clear  = 1'b1;
                    state_next = st_idle;
                end else if (|term_saved) begin
                    // lanes 1..3 map onto the 1..3 byte comparisons
                    last_fcs_ok_next = |(term_saved[3:1] & match.hit[2:0]);
                    state_next = st_last;
                end else begin
                    // hold match once the terminate word has been consumed
                    crc_update = !flags.term[0];
                end
            end
            st_last: begin
                beat_next.tdata  = stage2.data;
                beat_next.tkeep  = last_keep;
                beat_next.tvalid = 1'b1;
                beat_next.tlast  = 1'b1;
                if (last_ctrl_bad) begin
                    beat_next.tuser = 1'b1;
                    status_next.bad_frame = 1'b1;
                end else if (!last_fcs_ok) begin
                    beat_next.tuser = 1'b1;
                    status_next.bad_frame = 1'b1;
                    status_next.bad_fcs   = 1'b1;
                end
                crc_clear = 1'b1;
                // a start right behind the terminate reaches idle on the next word
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state         <= st_idle;
            start_pipe    <= '0;
            m_axis.tvalid <= 1'b0;
            m_axis.tlast  <= 1'b0;
            m_axis.tuser  <= 1'b0;
            status        <= '0;
        end else begin
            state         <= state_next;
            start_pipe    <= {start_pipe[0], flags.start[0]};
            m_axis.tvalid <= beat_next.tvalid;
            m_axis.tlast  <= beat_next.tlast;
            m_axis.tuser  <= beat_next.tuser;
            status        <= status_next;
        end
        m_axis.tdata <= beat_next.tdata;
        m_axis.tkeep <= beat_next.tkeep;
        last_fcs_ok  <= last_fcs_ok_next;
        // captured while the terminate word sits in stage0
        if (|flags.term) begin
            last_keep     <= flags.keep_mask;
            last_ctrl_bad <= |flags.ctrl_masked;
        end
    end

endmodule

// ==== source/xgmii_lane_decode.sv ====
/*
 * XGMII lane decode
 * registers the receive lanes into a three word pipeline and
 * classifies each lane of the newest word as start, terminate or
 * error; lanes at and above the first terminate are masked off
 */
`timescale 1ns/1ps

module xgmii_lane_decode (
    input  logic                     clk,
    input  logic                     reset_crc,
    input  xgmii_rx_pkg::xgmii_word_t rx,
    output xgmii_rx_pkg::xgmii_word_t stage0,
    output xgmii_rx_pkg::xgmii_word_t stage1,
    output xgmii_rx_pkg::xgmii_word_t stage2,
    output xgmii_rx_pkg::lane_flags_t flags,
    output logic [3:0]               term_saved
);

    import xgmii_rx_pkg::*;

    // raw error hits before masking
    logic [3:0] err_lane;

    // word pipeline
    always_ff @(posedge clk) begin
        if (reset_crc) begin
            stage0.ctrl <= '0;
            stage1.ctrl <= '0;
            stage2.ctrl <= '0;
            term_saved  <= '0;
        end else begin
            stage0.ctrl <= rx.ctrl;
            stage1.ctrl <= stage0.ctrl;
            stage2.ctrl <= stage1.ctrl;
            // terminate position of the word now moving into stage1
            term_saved  <= flags.term;
        end
        stage0.data <= rx.data;
        stage1.data <= stage0.data;
        stage2.data <= stage1.data;
    end

    // per-lane control character detect
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            flags.start[i] = stage0.ctrl[i] && (stage0.data[8*i +: 8] == xgmii_start);
            flags.term[i]  = stage0.ctrl[i] && (stage0.data[8*i +: 8] == xgmii_term);
            err_lane[i]    = stage0.ctrl[i] && (stage0.data[8*i +: 8] == xgmii_error);
        end
    end

    // lanes below the lowest terminate still belong to the packet
    always_comb begin
        logic term_seen;
        term_seen = 1'b0;
        for (int i = 0; i < 4; i++) begin
            term_seen = term_seen | flags.term[i];
            flags.keep_mask[i] = !term_seen;
        end
        // no terminate gives 1111, terminate on lane k leaves the low k lanes
        flags.err_masked  = err_lane & flags.keep_mask;
        flags.ctrl_masked = stage0.ctrl & flags.keep_mask;
    end

endmodule

// ==== source/xgmii_rx_pkg.sv ====
/*
 * XGMII receive package
 * control codes, CRC-32 constants, FSM state encoding and the
 * structs passed between the receive pipeline blocks, plus the
 * single-byte CRC step shared by the engine and the testbench model
 */
package xgmii_rx_pkg;

    // xgmii control codes
    localparam logic [7:0] xgmii_start = 8'hfb;
    localparam logic [7:0] xgmii_term  = 8'hfd;
    localparam logic [7:0] xgmii_error = 8'hfe;
    localparam logic [7:0] xgmii_idle  = 8'h07;

    // ethernet crc-32, normal form of the polynomial
    localparam logic [31:0] crc_poly    = 32'h04c1_1db7;
    localparam logic [31:0] crc_init    = 32'hffff_ffff;
    // remainder left in the register after data plus a good fcs
    localparam logic [31:0] crc_residue = ~32'h2144_df1c;

    typedef enum logic [1:0] {
        st_idle,
        st_preamble,
        st_payload,
        st_last
    } fsm_state_t;

    // one xgmii lane word, lane 0 in the low byte
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  ctrl;
    } xgmii_word_t;

    // per-lane decisions taken on the stage0 word
    typedef struct packed {
        logic [3:0] start;
        logic [3:0] term;
        logic [3:0] err_masked;
        logic [3:0] ctrl_masked;
        logic [3:0] keep_mask;
    } lane_flags_t;

    // bit i set when the (i+1)-byte update hit the residue
    typedef struct packed {
        logic [3:0] hit;
    } crc_match_t;

    typedef struct packed {
        logic [31:0] tdata;
        logic [3:0]  tkeep;
        logic        tvalid;
        logic        tlast;
        logic        tuser;
    } axis_beat_t;

    typedef struct packed {
        logic bad_frame;
        logic bad_fcs;
    } rx_status_t;

    // reflected galois step, one byte, lsb first
    function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] poly_r;
        logic [31:0] c;
        poly_r = {<<{crc_poly}};
        c = crc ^ {24'd0, data};
        for (int b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ poly_r) : (c >> 1);
        end
        return c;
    endfunction

endpackage

// ==== source/xgmii_rx_top.sv ====
/*
 * XGMII frame receiver, 32-bit
 * lane decode, CRC-32 engine and frame FSM; a word on rx
 * leaves as a beat four cycles later
 */
`timescale 1ns/1ps

module xgmii_rx_top (
    input  logic                     clk,
    input  logic                     reset_crc,
    input  xgmii_rx_pkg::xgmii_word_t rx,
    output xgmii_rx_pkg::axis_beat_t  m_axis,
    output xgmii_rx_pkg::rx_status_t  status
);

    import xgmii_rx_pkg::*;

    xgmii_word_t stage0;
    xgmii_word_t stage1;
    xgmii_word_t stage2;
    lane_flags_t flags;
    logic [3:0]  term_saved;
    crc_match_t  match;
    logic        crc_clear;
    logic        crc_update;

    xgmii_lane_decode u_decode (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .rx         (rx),
        .stage0     (stage0),
        .stage1     (stage1),
        .stage2     (stage2),
        .flags      (flags),
        .term_saved (term_saved)
    );

    eth_crc32_engine u_crc (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .data       (stage0.data),
        .match      (match)
    );

    xgmii_frame_fsm u_fsm (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .stage1     (stage1),
        .stage2     (stage2),
        .flags      (flags),
        .term_saved (term_saved),
        .match      (match),
        .m_axis     (m_axis),
        .status     (status),
        .crc_clear  (crc_clear),
        .crc_update (crc_update)
    );

endmodule

// ==== testbench/tb_xgmii_rx.sv ====
/*
 * XGMII receiver testbench
 * reads frames from the stimulus file, appends the FCS, drives them
 * as XGMII words with idle gaps and checks every beat and status pulse
 */
`timescale 1ns/1ps

module tb_xgmii_rx;

    import xgmii_rx_pkg::*;

    typedef struct packed {
        axis_beat_t beat;
        rx_status_t status;
        logic       check_data;
    } expect_t;

    localparam xgmii_word_t idle_word = '{data: 32'h0707_0707, ctrl: 4'b1111};
    // start on lane 0, preamble bytes above it
    localparam xgmii_word_t start_word = '{data: 32'h5555_55fb, ctrl: 4'b0001};
    // preamble tail with the sfd in lane 3
    localparam xgmii_word_t sfd_word = '{data: 32'hd555_5555, ctrl: 4'b0000};

    logic        clk;
    logic        reset_crc;
    xgmii_word_t rx;
    axis_beat_t  m_axis;
    rx_status_t  status;

    logic [7:0]  stim_mem [0:511];
    xgmii_word_t words [$];
    expect_t     expected [$];
    logic [31:0] rand_state;
    int          cycle = 0;
    int          cycle_limit = 0;
    int          first_data_idx = -1;
    int          first_data_cycle = 0;
    bit          first_beat_seen = 1'b0;
    int          beat_errors = 0;
    int          status_errors = 0;
    int          other_errors = 0;

    xgmii_rx_top UUT (
        .clk       (clk),
        .reset_crc (reset_crc),
        .rx        (rx),
        .m_axis    (m_axis),
        .status    (status)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // bitwise reflected crc-32, edb88320 is the reversed polynomial
    function automatic logic [31:0] fcs_byte(input logic [31:0] crc, input logic [7:0] b);
        crc = crc ^ {24'd0, b};
        for (int i = 0; i < 8; i++) begin
            crc = crc[0] ? ((crc >> 1) ^ 32'hedb8_8320) : (crc >> 1);
        end
        return crc;
    endfunction

    // record layout: mode, arg, status, length, payload bytes
    task automatic add_frame(input int base, output int next_base);
        logic [7:0]  mode;
        logic [7:0]  arg;
        rx_status_t  exp_status;
        int          len;
        int          total;
        int          lanes;
        int          err_pos;
        int          last_w;
        logic [31:0] crc;
        logic [7:0]  bytes [$];
        xgmii_word_t body [$];
        xgmii_word_t w;
        expect_t     e;
        mode       = stim_mem[base];
        arg        = stim_mem[base+1];
        exp_status = rx_status_t'(stim_mem[base+2][1:0]);
        len        = stim_mem[base+3];
        next_base  = base + 4 + len;
        crc        = 32'hffff_ffff;
        for (int i = 0; i < len; i++) begin
            bytes.push_back(stim_mem[base+4+i]);
            crc = fcs_byte(crc, stim_mem[base+4+i]);
        end
        crc = ~crc;
        if (mode == 8'h01) begin
            crc[arg[4:0]] = ~crc[arg[4:0]];
        end
        for (int i = 0; i < 4; i++) begin
            bytes.push_back(crc[8*i +: 8]);
        end
        total   = len + 4;
        lanes   = total % 4;
        err_pos = (mode == 8'h02) ? int'(arg) : -1;
        assert (mode != 8'h03 || lanes == arg) else begin
            $display("stimulus record at %0d ends on lane %0d, not lane %0d", base, lanes, arg);
            other_errors++;
        end
        // data lanes, then terminate, then idles to the word boundary
        for (int wi = 0; wi <= total / 4; wi++) begin
            for (int l = 0; l < 4; l++) begin
                if (4*wi + l < total) begin
                    w.data[8*l +: 8] = (4*wi + l == err_pos) ? xgmii_error : bytes[4*wi + l];
                    w.ctrl[l]        = (4*wi + l == err_pos);
                end else begin
                    w.data[8*l +: 8] = (4*wi + l == total) ? xgmii_term : xgmii_idle;
                    w.ctrl[l]        = 1'b1;
                end
            end
            body.push_back(w);
        end
        words.push_back(start_word);
        words.push_back(sfd_word);
        if (first_data_idx < 0) begin
            first_data_idx = words.size();
        end
        foreach (body[i]) begin
            words.push_back(body[i]);
        end
        if (err_pos >= 0 && err_pos < 4) begin
            // error in the first data word cuts the frame to one flagged beat
            e = '0;
            e.beat.tkeep  = 4'b0001;
            e.beat.tvalid = 1'b1;
            e.beat.tlast  = 1'b1;
            e.beat.tuser  = 1'b1;
            e.status      = exp_status;
            expected.push_back(e);
        end else begin
            last_w = (err_pos >= 0) ? err_pos / 4 : (total - 1) / 4;
            for (int wi = 0; wi <= last_w; wi++) begin
                e = '0;
                e.beat.tdata  = body[wi].data;
                e.beat.tkeep  = (wi == total / 4) ? 4'((1 << lanes) - 1) : 4'b1111;
                e.beat.tvalid = 1'b1;
                e.beat.tlast  = (wi == last_w);
                e.beat.tuser  = (wi == last_w) && exp_status.bad_frame;
                if (wi == last_w) begin
                    e.status = exp_status;
                end
                e.check_data  = 1'b1;
                expected.push_back(e);
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want, input bit is_status);
        assert (got === want) else begin
            $display("error %0t %s got %h expected %h", $time, name, got, want);
            if (is_status) begin
                status_errors++;
            end else begin
                beat_errors++;
            end
        end
    endtask

    task automatic check_beat(input expect_t ref_beat);
        logic [31:0] mask;
        for (int i = 0; i < 4; i++) begin
            mask[8*i +: 8] = {8{ref_beat.beat.tkeep[i] & ref_beat.check_data}};
        end
        check_value("m_axis.tdata", m_axis.tdata & mask, ref_beat.beat.tdata & mask, 1'b0);
        check_value("m_axis.tkeep", m_axis.tkeep, ref_beat.beat.tkeep, 1'b0);
        check_value("m_axis.tlast", m_axis.tlast, ref_beat.beat.tlast, 1'b0);
        check_value("m_axis.tuser", m_axis.tuser, ref_beat.beat.tuser, 1'b0);
        check_value("status.bad_frame", status.bad_frame, ref_beat.status.bad_frame, 1'b1);
        check_value("status.bad_fcs", status.bad_fcs, ref_beat.status.bad_fcs, 1'b1);
    endtask

    initial begin
        int base;
        int frames;
        int gap;
        clk        = 1'b0;
        reset_crc  = 1'b1;
        rx         = idle_word;
        rand_state = 32'h868d_9eff;
        $readmemh("testbench/xgmii_rx_stimulus.txt", stim_mem);
        assert (!$isunknown(stim_mem[0])) else begin
            $display("stimulus file could not be read");
            other_errors++;
        end
        repeat (3) words.push_back(idle_word);
        base   = 0;
        frames = 0;
        while (base < 480 && !$isunknown(stim_mem[base]) && stim_mem[base] != 8'hff) begin
            add_frame(base, base);
            rand_state = xorshift32(rand_state);
            // every third gap is the minimum single idle
            gap = (frames % 3 == 0) ? 1 : 1 + int'(rand_state % 4);
            repeat (gap) words.push_back(idle_word);
            frames++;
        end
        cycle_limit = words.size() + 8 * frames + 50;
        repeat (5) @(posedge clk);
        #10;
        reset_crc = 1'b0;
        foreach (words[i]) begin
            rx = words[i];
            if (i == first_data_idx) begin
                first_data_cycle = cycle;
            end
            @(posedge clk);
            #10;
        end
        rx = idle_word;
        while (expected.size() != 0) begin
            @(posedge clk);
        end
        // stray beats after the last frame land here
        repeat (8) @(posedge clk);
        assert (first_beat_seen) else begin
            $display("no beat was received at all");
            other_errors++;
        end
        $display("errors: beat %0d, status %0d, other %0d, assertion %0d",
                 beat_errors, status_errors, other_errors,
                 UUT.u_fsm.u_fsm_assert.assert_failures);
        if (beat_errors + status_errors + other_errors
            + UUT.u_fsm.u_fsm_assert.assert_failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // outputs sampled mid-cycle, away from the register update
    always @(negedge clk) begin
        if (!reset_crc) begin
            if (m_axis.tvalid) begin
                assert (expected.size() != 0) else begin
                    $display("beat at %0t arrived with no frame outstanding", $time);
                    other_errors++;
                end
                if (expected.size() != 0) begin
                    check_beat(expected.pop_front());
                end
                if (!first_beat_seen) begin
                    first_beat_seen = 1'b1;
                    check_value("first beat latency", cycle - first_data_cycle, 4, 1'b0);
                end
            end else begin
                assert (status == '0 && !m_axis.tlast) else begin
                    $display("status or tlast raised at %0t without a valid beat", $time);
                    status_errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle_limit > 0 && cycle > cycle_limit) begin
            $display("timeout at cycle %0d with %0d beats never received", cycle, expected.size());
            $display("Simulation FAILED");
            $finish;
        end
    end

endmodule

// ==== testbench/xgmii_rx_assert.sv ====
/*
 * frame FSM protocol assertions
 * beat framing, status pulses and CRC control rules
 */
`timescale 1ns/1ps

module xgmii_rx_assert (
    input logic                     clk,
    input logic                     reset_crc,
    input xgmii_rx_pkg::axis_beat_t m_axis,
    input xgmii_rx_pkg::rx_status_t status,
    input logic                     crc_clear,
    input logic                     crc_update,
    input xgmii_rx_pkg::fsm_state_t state
);

    import xgmii_rx_pkg::*;

    int assert_failures = 0;

    last_needs_valid: assert property (@(posedge clk) disable iff (reset_crc)
        m_axis.tlast |-> m_axis.tvalid)
        else begin
            $error("tlast without tvalid");
            assert_failures++;
        end

    keep_not_empty: assert property (@(posedge clk) disable iff (reset_crc)
        m_axis.tvalid |-> (m_axis.tkeep != 4'b0000))
        else begin
            $error("valid beat with empty tkeep");
            assert_failures++;
        end

    // a bad fcs is always a bad frame, judged on the last beat
    fcs_on_last: assert property (@(posedge clk) disable iff (reset_crc)
        status.bad_fcs |-> (status.bad_frame && m_axis.tlast))
        else begin
            $error("bad_fcs without bad_frame and tlast");
            assert_failures++;
        end

    // first update of a frame starts from a cleared crc
    crc_clear_before_frame: assert property (@(posedge clk) disable iff (reset_crc)
        (crc_update && state == st_idle) |-> $past(crc_clear))
        else begin
            $error("frame crc started without a preceding clear");
            assert_failures++;
        end

endmodule

bind xgmii_frame_fsm xgmii_rx_assert u_fsm_assert (
    .clk        (clk),
    .reset_crc  (reset_crc),
    .m_axis     (m_axis),
    .status     (status),
    .crc_clear  (crc_clear),
    .crc_update (crc_update),
    .state      (state)
);

// ==== testbench/xgmii_rx_stimulus.txt ====
// mode arg status len, then len payload bytes; all hex, ff ends the list
// mode 00 good, 01 bad_fcs (arg fcs bit), 02 err_char (arg byte), 03 term_lane (arg lane)
00 00 0 08 10 21 32 43 54 65 76 87
00 00 0 09 a0 b1 c2 d3 e4 f5 06 17 28
00 00 0 0a 3c 4d 5e 6f 70 81 92 a3 b4 c5
00 00 0 0b fb fd fe 07 55 d5 01 02 03 04 05
03 03 0 0f 00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee
01 05 3 0c de ad be ef 00 01 02 03 04 05 06 07
01 1f 3 0d c0 ff ee 12 34 56 78 9a bc de f0 0f 1e
02 09 2 10 01 23 45 67 89 ab cd ef fe dc ba 98 76 54 32 10
00 00 0 0e 5a a5 5a a5 11 22 33 44 99 88 77 66 e1 1e
02 02 2 0c 40 41 42 43 44 45 46 47 48 49 4a 4b
00 00 0 14 f0 e1 d2 c3 b4 a5 96 87 78 69 5a 4b 3c 2d 1e 0f 00 ff 00 ff
03 00 0 10 13 57 9b df 24 68 ac e0 31 75 b9 fd 42 86 ca 0e
03 01 0 11 80 70 60 50 40 30 20 10 00 f0 e0 d0 c0 b0 a0 90 88
03 02 0 12 01 02 04 08 10 20 40 80 ff fe fd fb f7 ef df bf 7f 00
01 10 3 0a 6b 2a 91 c4 0d 77 3e e8 52 19
01 00 3 0b 9c 61 af 03 d8 4e 27 b5 f2 6a 18
02 0c 2 18 a1 a2 a3 a4 b1 b2 b3 b4 c1 c2 c3 c4 d1 d2 d3 d4 e1 e2 e3 e4 f1 f2 f3 f4
00 00 0 08 ca fe ba be 0b ad f0 0d
ff
